// ==== design/ConvertPkg.sv ====
// Conversion widths, digit count, vector types and sequencer states

package ConvertPkg;

	// Width of the binary operand
	localparam int InputBits = 16;

	// Number of BCD digits in a result
	localparam int OutputDigits = 5;

	// Width of one BCD digit
	localparam int DigitBits = 4;

	// Packed BCD result width
	localparam int BcdBits = OutputDigits * DigitBits;

	// Width needed to count down the operand bits
	localparam int BitCountBits = $clog2(InputBits);

	// Binary operand as sampled from the caller
	typedef logic [InputBits-1:0] binaryT;

	// Five packed digits, ones digit in the low nibble
	typedef logic [BcdBits-1:0] bcdT;

	// One BCD digit
	typedef logic [DigitBits-1:0] digitT;

	// Remaining operand bits in a conversion
	typedef logic [BitCountBits-1:0] bitCountT;

	// Double shifts one bit in, Dabble applies the add-3 correction
	typedef enum logic [1:0] {
		Idle,
		Double,
		Dabble
	} sequencerStateT;

endpackage

// ==== design/DisplayPkg.sv ====
// Seven-segment, digit-select and scan types with the scan prescale constant

package DisplayPkg;

	// Clock cycles each digit stays lit
	// Kept short so a full scan fits in a short simulation
	localparam int ScanDivide = 4;

	// Width of the scan prescaler
	localparam int ScanCountBits = $clog2(ScanDivide);

	// Active-high segments, g f e d c b a from the top bit down
	typedef logic [6:0] segmentsT;

	// One-hot active-high digit enables, bit 0 is the ones digit
	typedef logic [4:0] digitSelectT;

	// Number of the digit being scanned, 0 to 4
	typedef logic [2:0] digitIndexT;

	// Prescaler count within one scan slot
	typedef logic [ScanCountBits-1:0] scanCountT;

endpackage

// ==== design/ConvertIf.sv ====
// Command interface between the conversion sequencer and the shift-add datapath
`timescale 1ns/100ps

interface ConvertIf;

	// Copy operand and clear the BCD register
	logic Load;

	// Double step, top operand bit moves into the BCD register
	logic Shift;

	// Dabble step, add three to each digit of five or more
	logic Adjust;

	// Hand the finished BCD value to the result register
	logic Capture;

	modport Sequencer (
		output Load,
		output Shift,
		output Adjust,
		output Capture
	);

	modport Datapath (
		input Load,
		input Shift,
		input Adjust,
		input Capture
	);

endinterface

// ==== design/ConversionSequencer.sv ====
// Double and dabble state machine with bit counter and command decode
`timescale 1ns/100ps

module ConversionSequencer (
	input  logic        Clock,
	input  logic        Reset,
	input  logic        Start_i,
	output logic        Busy_o,
	output logic        Done_o,
	ConvertIf.Sequencer Control
);
	import ConvertPkg::*;

	sequencerStateT State;
	bitCountT BitCount;
	logic Accept;
	logic LastStep;
	logic Finishing;

	// Start is ignored while a conversion is in flight
	assign Accept = Start_i && !Busy_o;

	// Final dabble of the last operand bit
	assign LastStep = (State == Dabble) && (BitCount == '0);

	// Busy stays up through the result hand-off cycle
	assign Busy_o = (State != Idle) || Finishing;

	assign Control.Load    = Accept;
	assign Control.Shift   = (State == Double);
	assign Control.Adjust  = (State == Dabble);
	assign Control.Capture = LastStep;

	always_ff @(posedge Clock or negedge Reset) begin
		if (!Reset) begin
			State     <= Idle;
			BitCount  <= '0;
			Finishing <= 1'b0;
			Done_o    <= 1'b0;
		end else begin
			Finishing <= LastStep;
			Done_o    <= Finishing;
			case (State)
				Idle: begin
					if (Accept) begin
						State    <= Double;
						BitCount <= bitCountT'(InputBits - 1);
					end
				end
				Double: begin
					State <= Dabble;
				end
				Dabble: begin
					if (BitCount == '0) begin
						State <= Idle;
					end else begin
						BitCount <= BitCount - 1'b1;
						State    <= Double;
					end
				end
				default: begin
					State <= Idle;
				end
			endcase
		end
	end

	// Done never overlaps busy
	assert property (@(posedge Clock) disable iff (!Reset) !(Busy_o && Done_o));

	// Load, Shift and Adjust exclusive, Capture only rides on Adjust
	assert property (@(posedge Clock) disable iff (!Reset)
		$onehot0({Control.Load, Control.Shift, Control.Adjust})
		&& (!Control.Capture || Control.Adjust));

endmodule

// ==== design/ShiftAdjustDatapath.sv ====
// Operand and BCD shift registers, add-3 adjust and the result register
`timescale 1ns/100ps

module ShiftAdjustDatapath (
	input  logic              Clock,
	input  logic              Reset,
	input  ConvertPkg::binaryT Binary_i,
	ConvertIf.Datapath        Control,
	output ConvertPkg::bcdT   Bcd_o,
	output logic              ResultStrobe_o
);
	import ConvertPkg::*;

	binaryT Operand;
	bcdT Work;
	bcdT Adjusted;
	logic CapturePending;

	function automatic logic DigitsValid(bcdT Value);
		logic Valid;
		Valid = 1'b1;
		for (int i = 0; i < OutputDigits; i++) begin
			if (Value[i*DigitBits +: DigitBits] > digitT'(9)) begin
				Valid = 1'b0;
			end
		end
		return Valid;
	endfunction

	// Add three to every digit of five or more
	always_comb begin
		digitT Digit;
		Adjusted = Work;
		for (int i = 0; i < OutputDigits; i++) begin
			Digit = Work[i*DigitBits +: DigitBits];
			if (Digit >= digitT'(5)) begin
				Adjusted[i*DigitBits +: DigitBits] = Digit + digitT'(3);
			end
		end
	end

	always_ff @(posedge Clock) begin
		if (Control.Load) begin
			Operand <= Binary_i;
			Work    <= '0;
		end else if (Control.Shift) begin
			Work    <= {Work[BcdBits-2:0], Operand[InputBits-1]};
			Operand <= {Operand[InputBits-2:0], 1'b0};
		end else if (Control.Adjust && !Control.Capture) begin
			Work <= Adjusted;
		end
		// Work is already final once the last bit is in, so it holds on Capture
	end

	always_ff @(posedge Clock or negedge Reset) begin
		if (!Reset) begin
			CapturePending <= 1'b0;
			ResultStrobe_o <= 1'b0;
			Bcd_o          <= '0;
		end else begin
			CapturePending <= Control.Capture;
			ResultStrobe_o <= CapturePending;
			if (CapturePending) begin
				Bcd_o <= Work;
			end
		end
	end

	// A digit above 9 after a shift means a missed adjust
	assert property (@(posedge Clock) disable iff (!Reset) Control.Shift |=> DigitsValid(Work));

endmodule

// ==== design/ScanTimer.sv ====
// Scan prescaler and digit index for the multiplexed display
`timescale 1ns/100ps

module ScanTimer (
	input  logic                   Clock,
	input  logic                   Reset,
	output logic                   ScanTick_o,
	output DisplayPkg::digitIndexT DigitIndex_o
);
	import ConvertPkg::*;
	import DisplayPkg::*;

	scanCountT Prescale;
	logic Wrap;

	// End of the current digit slot
	assign Wrap = (Prescale == scanCountT'(ScanDivide - 1));

	always_ff @(posedge Clock or negedge Reset) begin
		if (!Reset) begin
			Prescale     <= '0;
			ScanTick_o   <= 1'b0;
			DigitIndex_o <= '0;
		end else begin
			ScanTick_o <= Wrap;
			if (Wrap) begin
				Prescale <= '0;
				if (DigitIndex_o == digitIndexT'(OutputDigits - 1)) begin
					DigitIndex_o <= '0;
				end else begin
					DigitIndex_o <= DigitIndex_o + 1'b1;
				end
			end else begin
				Prescale <= Prescale + 1'b1;
			end
		end
	end

	// Index stays within the five digits
	assert property (@(posedge Clock) disable iff (!Reset)
		DigitIndex_o <= digitIndexT'(OutputDigits - 1));

endmodule

// ==== design/DisplayDriver.sv ====
// Held result, leading-zero blanking, digit select and seven-segment encoding
`timescale 1ns/100ps

module DisplayDriver (
	input  logic                    Clock,
	input  logic                    Reset,
	input  ConvertPkg::bcdT         Result_i,
	input  logic                    ResultStrobe_i,
	input  logic                    ScanTick_i,
	input  DisplayPkg::digitIndexT  DigitIndex_i,
	output DisplayPkg::digitSelectT DigitSelect_o,
	output DisplayPkg::segmentsT    Segments_o
);
	import ConvertPkg::*;
	import DisplayPkg::*;

	bcdT Held;
	logic [OutputDigits-1:0] Blank;
	digitT Digit;
	segmentsT Code;

	// Active-high segments g f e d c b a
	function automatic segmentsT Encode(digitT Value);
		case (Value)
			4'd0: return 7'h3F;
			4'd1: return 7'h06;
			4'd2: return 7'h5B;
			4'd3: return 7'h4F;
			4'd4: return 7'h66;
			4'd5: return 7'h6D;
			4'd6: return 7'h7D;
			4'd7: return 7'h07;
			4'd8: return 7'h7F;
			4'd9: return 7'h6F;
			default: return 7'h40;
		endcase
	endfunction

	always_ff @(posedge Clock or negedge Reset) begin
		if (!Reset) begin
			Held <= '0;
		end else if (ResultStrobe_i) begin
			Held <= Result_i;
		end
	end

	// Blank a digit when it and all higher digits are zero
	always_comb begin
		logic HigherZero;
		HigherZero = 1'b1;
		for (int i = OutputDigits - 1; i > 0; i--) begin
			HigherZero = HigherZero && (Held[i*DigitBits +: DigitBits] == '0);
			Blank[i] = HigherZero;
		end
		// Ones digit always lit
		Blank[0] = 1'b0;
	end

	assign Digit = Held[DigitIndex_i*DigitBits +: DigitBits];
	assign Code  = Encode(Digit);

	// Outputs move once per slot, right after the index changes
	always_ff @(posedge Clock or negedge Reset) begin
		if (!Reset) begin
			DigitSelect_o <= digitSelectT'(1);
			Segments_o    <= Encode('0);
		end else if (ScanTick_i) begin
			DigitSelect_o <= digitSelectT'(1) << DigitIndex_i;
			Segments_o    <= Blank[DigitIndex_i] ? '0 : Code;
		end
	end

endmodule

// ==== design/NumberDisplay.sv ====
// Top level joining BCD conversion and the multiplexed seven-segment display
`timescale 1ns/100ps

module NumberDisplay (
	input  logic                    Clock,
	input  logic                    Reset,
	input  logic                    Start_i,
	input  ConvertPkg::binaryT      Binary_i,
	output logic                    Busy_o,
	output logic                    Done_o,
	output ConvertPkg::bcdT         Bcd_o,
	output DisplayPkg::digitSelectT DigitSelect_o,
	output DisplayPkg::segmentsT    Segments_o
);
	import DisplayPkg::*;

	logic ResultStrobe;
	logic ScanTick;
	digitIndexT DigitIndex;

	ConvertIf Control ();

	ConversionSequencer Sequencer (
		.Clock   (Clock),
		.Reset   (Reset),
		.Start_i (Start_i),
		.Busy_o  (Busy_o),
		.Done_o  (Done_o),
		.Control (Control.Sequencer)
	);

	ShiftAdjustDatapath Datapath (
		.Clock          (Clock),
		.Reset          (Reset),
		.Binary_i       (Binary_i),
		.Control        (Control.Datapath),
		.Bcd_o          (Bcd_o),
		.ResultStrobe_o (ResultStrobe)
	);

	ScanTimer Scan (
		.Clock        (Clock),
		.Reset        (Reset),
		.ScanTick_o   (ScanTick),
		.DigitIndex_o (DigitIndex)
	);

	// Display takes the same result that leaves on Bcd_o
	DisplayDriver Display (
		.Clock          (Clock),
		.Reset          (Reset),
		.Result_i       (Bcd_o),
		.ResultStrobe_i (ResultStrobe),
		.ScanTick_i     (ScanTick),
		.DigitIndex_i   (DigitIndex),
		.DigitSelect_o  (DigitSelect_o),
		.Segments_o     (Segments_o)
	);

endmodule

// ==== testbench/NumberDisplayTb.sv ====
// Directed testbench for NumberDisplay with BCD and segment reference model and watchdog
`timescale 1ns/100ps

module NumberDisplayTb;
	import ConvertPkg::*;
	import DisplayPkg::*;

	localparam int ClockPeriod = 40;
	localparam int DriveDelay = 2;
	localparam int DoneEdge = 33;
	localparam int RandomCount = 40;
	// Known values, start-while-busy and two scan conversions on top of the random ones
	localparam int ConversionCount = RandomCount + 8;
	localparam int ConversionCycles = 40;
	localparam int ScanCycles = (OutputDigits + 2) * ScanDivide;
	localparam int TimeoutCycles = ConversionCount * ConversionCycles + 3 * ScanCycles + 200;

	logic Clock;
	logic Reset;
	logic Start_i;
	binaryT Binary_i;
	logic Busy_o;
	logic Done_o;
	bcdT Bcd_o;
	digitSelectT DigitSelect_o;
	segmentsT Segments_o;

	int errors;
	bcdT lastBcd;
	int unsigned knownOperands[5] = '{0, 9, 10, 65535, 255};

	NumberDisplay uut (
		.Clock         (Clock),
		.Reset         (Reset),
		.Start_i       (Start_i),
		.Binary_i      (Binary_i),
		.Busy_o        (Busy_o),
		.Done_o        (Done_o),
		.Bcd_o         (Bcd_o),
		.DigitSelect_o (DigitSelect_o),
		.Segments_o    (Segments_o)
	);

	initial begin
		Clock = 1'b0;
		forever #(ClockPeriod / 2) Clock = ~Clock;
	end

	// Decimal digits by repeated division, ones digit in the low nibble
	function automatic bcdT expectedBcd(int unsigned value);
		bcdT result;
		int unsigned rest;
		result = '0;
		rest = value;
		for (int i = 0; i < OutputDigits; i++) begin
			result[i*4 +: 4] = rest % 10;
			rest = rest / 10;
		end
		return result;
	endfunction

	// A digit is dark when the whole value is below its decimal weight
	function automatic logic digitBlank(int unsigned value, int index);
		int unsigned weight;
		weight = 1;
		repeat (index) weight = weight * 10;
		return (index != 0) && (value < weight);
	endfunction

	// Segments g f e d c b a
	function automatic segmentsT segmentCode(logic [3:0] digit);
		case (digit)
			4'd0: return 7'b0111111;
			4'd1: return 7'b0000110;
			4'd2: return 7'b1011011;
			4'd3: return 7'b1001111;
			4'd4: return 7'b1100110;
			4'd5: return 7'b1101101;
			4'd6: return 7'b1111101;
			4'd7: return 7'b0000111;
			4'd8: return 7'b1111111;
			4'd9: return 7'b1101111;
			default: return 7'b0000000;
		endcase
	endfunction

	task automatic compareValue(string test, string what, logic [31:0] expected,
		logic [31:0] actual);
		assert (expected == actual) else begin
			$display("MISMATCH %s %s: expected %0h, actual %0h", test, what, expected, actual);
			errors++;
		end
	endtask

	task automatic expectTrue(logic condition, string message);
		assert (condition) else begin
			$display("ERROR %s", message);
			errors++;
		end
	endtask

	// Starts one conversion, optionally pokes Start_i again at edge interruptAt
	task automatic convertValue(string test, int unsigned value, int interruptAt,
		int unsigned other);
		bcdT expected;
		int edges;
		expected = expectedBcd(value);
		expectTrue(!Busy_o, {test, ": converter busy before start"});
		Start_i = 1'b1;
		Binary_i = binaryT'(value);
		@(posedge Clock);
		#DriveDelay;
		Start_i = 1'b0;
		Binary_i = ~binaryT'(value);
		expectTrue(Busy_o, {test, ": Busy_o did not rise one cycle after Start_i"});
		edges = 0;
		while (!Done_o && edges < ConversionCycles) begin
			@(posedge Clock);
			#DriveDelay;
			edges++;
			if (edges == interruptAt) begin
				Start_i = 1'b1;
				Binary_i = binaryT'(other);
			end else begin
				Start_i = 1'b0;
			end
			if (!Done_o) begin
				compareValue(test, "held Bcd_o", lastBcd, Bcd_o);
			end
		end
		Start_i = 1'b0;
		if (!Done_o) begin
			expectTrue(1'b0, {test, ": Done_o never pulsed"});
		end else begin
			compareValue(test, "done edge", DoneEdge, edges);
			compareValue(test, "Bcd_o", expected, Bcd_o);
			expectTrue(!Busy_o, {test, ": Busy_o still high with Done_o"});
			lastBcd = Bcd_o;
			@(posedge Clock);
			#DriveDelay;
			expectTrue(!Done_o, {test, ": Done_o longer than one cycle"});
			expectTrue(!Busy_o, {test, ": a second conversion was started"});
			compareValue(test, "Bcd_o after done", lastBcd, Bcd_o);
		end
	endtask

	// Follows the select through five slots and checks each digit shown
	task automatic scanDisplay(string test, int unsigned value);
		bcdT digits;
		digitSelectT seen;
		digitSelectT previous;
		segmentsT expectedSegments;
		int index;
		int guard;
		digits = expectedBcd(value);
		seen = '0;
		for (int slot = 0; slot < OutputDigits; slot++) begin
			previous = DigitSelect_o;
			guard = 0;
			while (DigitSelect_o == previous && guard < ScanCycles) begin
				@(posedge Clock);
				#DriveDelay;
				guard++;
			end
			if (DigitSelect_o == previous) begin
				expectTrue(1'b0, {test, ": digit select stopped changing"});
				return;
			end
			expectTrue($onehot(DigitSelect_o), {test, ": digit select not one-hot"});
			index = 0;
			for (int i = 0; i < OutputDigits; i++) begin
				if (DigitSelect_o[i]) index = i;
			end
			expectedSegments = digitBlank(value, index) ? '0 : segmentCode(digits[index*4 +: 4]);
			compareValue(test, $sformatf("segments of digit %0d", index), expectedSegments,
				Segments_o);
			seen = seen | DigitSelect_o;
		end
		compareValue(test, "digits scanned", 5'h1F, seen);
	endtask

	task automatic resetState();
		compareValue("reset", "Busy_o", 0, Busy_o);
		compareValue("reset", "Done_o", 0, Done_o);
		compareValue("reset", "Bcd_o", 0, Bcd_o);
		compareValue("reset", "digit select", 5'h01, DigitSelect_o);
		compareValue("reset", "segments", segmentCode(4'd0), Segments_o);
		scanDisplay("reset", 0);
	endtask

	task automatic knownValues();
		foreach (knownOperands[i]) begin
			convertValue($sformatf("known %0d", knownOperands[i]), knownOperands[i], 0, 0);
		end
	endtask

	task automatic randomValues();
		int unsigned value;
		for (int i = 0; i < RandomCount; i++) begin
			value = $urandom & 32'hFFFF;
			convertValue($sformatf("random %0d", i), value, 0, 0);
		end
	endtask

	// Second request lands mid-conversion with another operand
	task automatic startWhileBusy();
		convertValue("start while busy", 4321, 10, 4321 ^ 16'h5A5A);
	endtask

	task automatic displayScan();
		convertValue("scan 1207", 1207, 0, 0);
		scanDisplay("scan 1207", 1207);
		convertValue("scan 0", 0, 0, 0);
		scanDisplay("scan 0", 0);
	endtask

	initial begin
		errors = 0;
		lastBcd = '0;
		Reset = 1'b0;
		Start_i = 1'b0;
		Binary_i = '0;
		void'($urandom(32'hff5c));
		repeat (2) @(posedge Clock);
		#DriveDelay;
		Reset = 1'b1;
		resetState();
		knownValues();
		randomValues();
		startWhileBusy();
		displayScan();
		$display("Errors: %0d", errors);
		if (errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(TimeoutCycles * ClockPeriod);
		$display("Run timed out after %0d cycles, errors so far: %0d", TimeoutCycles, errors);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

// ==== sim.f ====
design/ConvertPkg.sv
design/DisplayPkg.sv
design/ConvertIf.sv
design/ConversionSequencer.sv
design/ShiftAdjustDatapath.sv
design/ScanTimer.sv
design/DisplayDriver.sv
design/NumberDisplay.sv
testbench/NumberDisplayTb.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module NumberDisplayTb \
		-f sim.f -Mdir obj_dir
	./obj_dir/VNumberDisplayTb | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
